// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_controller
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_pipe_controller.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_controller
    import ctrl_pkg::*;
();

    logic           clk;
    logic           reset;
    instr_fields_t  dinstr;
    compare_flags_t dcompare;
    stage_mask_t    flush;
    stage_mask_t    stall;
    ctrl_word_t     dstage;
    ctrl_word_t     estage;
    ctrl_word_t     mstage;
    ctrl_word_t     wstage;

    pipe_controller i_pipe_controller (
        .clk      (clk),
        .reset    (reset),
        .dinstr   (dinstr),
        .dcompare (dcompare),
        .flush    (flush),
        .stall    (stall),
        .dstage   (dstage),
        .estage   (estage),
        .mstage   (mstage),
        .wstage   (wstage)
    );

    always #10 clk = ~clk;

    initial
    begin
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
    end

    function automatic instr_fields_t special_fn(funct_t funct);
        instr_fields_t f;
        f = '0;
        f.funct = funct;
        return f;
    endfunction

    function automatic instr_fields_t major_op(opcode_t op);
        instr_fields_t f;
        f = '0;
        f.op = op;
        return f;
    endfunction

    function automatic instr_fields_t regimm_sel(regimm_t rt);
        instr_fields_t f;
        f = '0;
        f.op = 6'b000001;
        f.regimm = rt;
        return f;
    endfunction

    // Branch condition against rs/rt compare flags
    function automatic logic expected_taken(branch_cond_e cond, compare_flags_t c);
        case (cond)
            BR_EQ:            return c.equal;
            BR_NE:            return !c.equal;
            BR_GEZ, BR_GEZAL: return c.g0 || c.e0;
            BR_GTZ:           return c.g0;
            BR_LEZ:           return !c.g0;
            default:          return !(c.g0 || c.e0);     // LTZ and LTZAL
        endcase
    endfunction

    task automatic abort_run(string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_field(string name, int expected, int actual);
        assert (actual == expected)
        else
            abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic check_clear(string name, ctrl_word_t actual);
        assert (actual == '0)
        else
            abort_run($sformatf("FAILED %s: expected 0, actual %h", name, actual));
    endtask

    task automatic check_alu(string name, ctrl_word_t w, alu_func_e func);
        check_field({name, " regwrite"}, 1, int'(w.regwrite));
        check_field({name, " alu_func"}, int'(func), int'(w.alu_func));
    endtask

    // New inputs 2 ns after the edge and outputs sampled at the falling edge
    task automatic drive(instr_fields_t f, compare_flags_t c, stage_mask_t st,
                         stage_mask_t fl);
        @(posedge clk);
        #2;
        dinstr = f;
        dcompare = c;
        stall = st;
        flush = fl;
        @(negedge clk);
    endtask

    task automatic issue(instr_fields_t f);
        drive(f, '0, '0, '0);
    endtask

    task automatic reset_values();
        check_clear("reset estage", estage);
        check_clear("reset mstage", mstage);
        check_clear("reset wstage", wstage);
    endtask

    task automatic alu_decode();
        issue(special_fn(6'h20));                     // ADD
        check_alu("add", dstage, ALU_ADD);
        check_field("add regdst", int'(REGDST_RD), int'(dstage.regdst));
        check_field("add intovf_en", 1, int'(dstage.intovf_en));
        check_field("add alu_srcb_sel_rt", 1, int'(dstage.alu_srcb_sel_rt));
        issue(major_op(6'h09));                       // ADDIU
        check_field("addiu regdst", int'(REGDST_RT), int'(dstage.regdst));
        check_field("addiu imm_sign", 1, int'(dstage.imm_sign));
        check_field("addiu intovf_en", 0, int'(dstage.intovf_en));
        issue(special_fn(6'h04));                     // SLLV
        check_field("sllv out_sel", int'(OUT_SHIFT), int'(dstage.out_sel));
        check_field("sllv sft_func", int'(SFT_SLL), int'(dstage.sft_func));
        check_field("sllv sft_srcb_sel_rs", 1, int'(dstage.sft_srcb_sel_rs));
        issue(major_op(6'h0f));                       // LUI
        check_field("lui sft_srca_sel_imm", 1, int'(dstage.sft_srca_sel_imm));
        issue(special_fn(6'h18));                     // MULT
        check_field("mult mul_en", 1, int'(dstage.mul_en));
        check_field("mult mul_sign", 1, int'(dstage.mul_sign));
        check_field("mult hi_sel", int'(HILO_MUL), int'(dstage.hi_sel));
        check_field("mult lo_sel", int'(HILO_MUL), int'(dstage.lo_sel));
        check_field("mult hi_wen", 1, int'(dstage.hi_wen));
        check_field("mult lo_wen", 1, int'(dstage.lo_wen));
        issue(special_fn(6'h13));                     // MTLO
        check_field("mtlo lo_sel", int'(HILO_MOVE), int'(dstage.lo_sel));
        check_field("mtlo lo_wen", 1, int'(dstage.lo_wen));
        check_field("mtlo hi_wen", 0, int'(dstage.hi_wen));
        issue(special_fn(6'h10));                     // MFHI
        check_field("mfhi out_sel", int'(OUT_HI), int'(dstage.out_sel));
    endtask

    task automatic load_store_decode();
        issue(major_op(6'h20));                       // LB
        check_field("lb memreq", 1, int'(dstage.memreq));
        check_field("lb memtoreg", 1, int'(dstage.memtoreg));
        check_field("lb rdata_sign", 1, int'(dstage.rdata_sign));
        check_field("lb size", int'(SIZE_BYTE), int'(dstage.size));
        issue(major_op(6'h25));                       // LHU
        check_field("lhu size", int'(SIZE_HALF), int'(dstage.size));
        check_field("lhu rdata_sign", 0, int'(dstage.rdata_sign));
        issue(major_op(6'h2b));                       // SW
        check_field("sw memreq", 1, int'(dstage.memreq));
        check_field("sw memwr", 1, int'(dstage.memwr));
        check_field("sw size", int'(SIZE_WORD), int'(dstage.size));
        check_field("sw regwrite", 0, int'(dstage.regwrite));
    endtask

    task automatic branch_jump_decode();
        instr_fields_t  br_instr [8];
        branch_cond_e   br_cond [8];
        compare_flags_t flags;
        logic [31:0]    rnd;
        br_instr = '{major_op(6'h04), major_op(6'h05), major_op(6'h06), major_op(6'h07),
                     regimm_sel(5'h00), regimm_sel(5'h01), regimm_sel(5'h10),
                     regimm_sel(5'h11)};
        br_cond = '{BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ, BR_LTZAL, BR_GEZAL};
        for (int i = 0; i < 8; i++)
        begin
            for (int j = 0; j < 8; j++)
            begin
                rnd = $urandom;
                flags = rnd[2:0];
                drive(br_instr[i], flags, '0, '0);
                check_field($sformatf("branch %0d isbranch", i), 1, int'(dstage.isbranch));
                check_field($sformatf("branch %0d cond", i), int'(br_cond[i]),
                            int'(dstage.branch));
                check_field($sformatf("branch %0d pcsrc", i),
                            int'(expected_taken(br_cond[i], flags)), int'(dstage.pcsrc));
            end
        end
        issue(regimm_sel(5'h11));                     // BGEZAL
        check_field("bgezal link", 1, int'(dstage.link));
        check_field("bgezal regdst", int'(REGDST_RA), int'(dstage.regdst));
        issue(major_op(6'h03));                       // JAL
        check_field("jal isjump", 1, int'(dstage.isjump));
        check_field("jal jump", int'(JMP_JAL), int'(dstage.jump));
        check_field("jal link", 1, int'(dstage.link));
        check_field("jal regdst", int'(REGDST_RA), int'(dstage.regdst));
        issue(special_fn(6'h08));                     // JR
        check_field("jr jump", int'(JMP_JR), int'(dstage.jump));
        check_field("jr regwrite", 0, int'(dstage.regwrite));
    endtask

    // Masks take effect at the edge that opens the next drive
    task automatic pipeline_movement();
        issue(special_fn(6'h22));                     // SUB
        check_alu("pipe dstage", dstage, ALU_SUB);
        issue(special_fn(6'h24));                     // AND
        check_alu("pipe estage", estage, ALU_SUB);
        issue(special_fn(6'h25));                     // OR
        check_alu("pipe mstage", mstage, ALU_SUB);
        check_alu("pipe estage and", estage, ALU_AND);
        drive(special_fn(6'h26), '0, 3'b010, 3'b000); // XOR with memory stall next
        check_alu("pipe wstage", wstage, ALU_SUB);
        check_alu("pipe mstage and", mstage, ALU_AND);
        drive(special_fn(6'h27), '0, 3'b001, 3'b001); // NOR with flush and stall on execute
        check_alu("stall mstage", mstage, ALU_AND);
        check_alu("stall estage", estage, ALU_XOR);
        check_alu("stall wstage", wstage, ALU_AND);
        drive(special_fn(6'h20), '0, 3'b000, 3'b100); // ADD with writeback flush next
        check_clear("flush estage", estage);
        check_alu("flush mstage", mstage, ALU_XOR);
        issue(special_fn(6'h22));
        check_clear("flush wstage", wstage);
        check_clear("bubble mstage", mstage);
        check_alu("refill estage", estage, ALU_ADD);
    endtask

    task automatic reserved_decode();
        instr_fields_t bad [3];
        bad = '{major_op(6'h3f), special_fn(6'h01), major_op(6'h10)};   // Last is COP0
        for (int i = 0; i < 3; i++)
        begin
            issue(bad[i]);
            check_field($sformatf("reserved %0d flag", i), 1, int'(dstage.reserved_instr));
            check_field($sformatf("reserved %0d regwrite", i), 0, int'(dstage.regwrite));
            check_field($sformatf("reserved %0d memreq", i), 0, int'(dstage.memreq));
        end
    endtask

    initial
    begin
        int cycles;
        clk = 1'b0;
        reset = 1'b1;
        dinstr = '0;
        dcompare = '0;
        flush = '0;
        stall = '0;
        void'($urandom(65));
        cycles = 0;
        while (reset && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (reset)
            abort_run("Reset was still high after 20 cycles");
        else
        begin
            reset_values();
            alu_decode();
            load_store_decode();
            branch_jump_decode();
            pipeline_movement();
            reserved_decode();
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: source/branch_resolver.sv
`timescale 1ns/100ps
`default_nettype none

module branch_resolver
    import ctrl_pkg::*;
(
    input  ctrl_word_t     ctrl_in,
    input  compare_flags_t compare,
    output ctrl_word_t     ctrl_out
);

    logic taken;

    always_comb
    begin
        taken = 1'b0;
        case (ctrl_in.branch)
            BR_EQ:              taken = compare.equal;
            BR_NE:              taken = ~compare.equal;
            BR_GEZ, BR_GEZAL:   taken = compare.g0 | compare.e0;
            BR_GTZ:             taken = compare.g0;
            BR_LEZ:             taken = ~compare.g0;
            BR_LTZ, BR_LTZAL:   taken = ~(compare.g0 | compare.e0);   // Negative rs
        endcase
    end

    // Only pcsrc changes on the way through
    always_comb
    begin
        ctrl_out = ctrl_in;
        ctrl_out.pcsrc = ctrl_in.isbranch & taken;
    end

endmodule

`default_nettype wire

// File: source/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Decode-stage instruction field widths
`define CTRL_OP_W      6
`define CTRL_FUNCT_W   6
`define CTRL_REGIMM_W  5

// Stage registers behind decode for execute, memory and writeback
`define CTRL_STAGES    3

`endif

// File: source/ctrl_pkg.sv
`default_nettype none

`include "ctrl_config.svh"

package ctrl_pkg;

    typedef logic [`CTRL_OP_W-1:0]     opcode_t;
    typedef logic [`CTRL_FUNCT_W-1:0]  funct_t;
    typedef logic [`CTRL_REGIMM_W-1:0] regimm_t;
    typedef logic [`CTRL_STAGES-1:0]   stage_mask_t;   // Bit 0 execute, 2 writeback

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR, ALU_XOR
    } alu_func_e;

    typedef enum logic [1:0] {
        SFT_LUI, SFT_SLL, SFT_SRA, SFT_SRL
    } sft_func_e;

    // Writeback result source
    typedef enum logic [2:0] {
        OUT_ALU   = 3'd0,
        OUT_SHIFT = 3'd1,
        OUT_HI    = 3'd2,
        OUT_LO    = 3'd3
    } out_sel_e;

    typedef enum logic [1:0] {
        REGDST_RT = 2'd0,
        REGDST_RD = 2'd1,
        REGDST_RA = 2'd2                              // r31 for link
    } regdst_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZAL, BR_LTZAL
    } branch_cond_e;

    typedef enum logic [1:0] {
        JMP_J    = 2'd0,
        JMP_JR   = 2'd1,
        JMP_JAL  = 2'd2,
        JMP_JALR = 2'd3
    } jump_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE, SIZE_HALF, SIZE_WORD
    } mem_size_e;

    typedef enum logic [1:0] {
        HILO_MUL  = 2'd0,
        HILO_DIV  = 2'd1,
        HILO_MOVE = 2'd2                              // Written from rs
    } hilo_sel_e;

    typedef struct packed {
        opcode_t op;
        funct_t  funct;
        regimm_t regimm;
    } instr_fields_t;

    typedef struct packed {
        logic equal;                                  // rs == rt
        logic g0;                                     // rs > 0
        logic e0;                                     // rs == 0
    } compare_flags_t;

    typedef struct packed {
        logic         alu_srcb_sel_rt;
        logic         sft_srcb_sel_rs;
        logic         sft_srca_sel_imm;
        out_sel_e     out_sel;
        logic         regwrite;
        regdst_e      regdst;
        logic         reserved_instr;
        logic         link;
        logic         isbranch;
        logic         isjump;
        branch_cond_e branch;
        jump_kind_e   jump;
        logic         memreq;
        logic         memwr;
        mem_size_e    size;
        logic         rdata_sign;
        logic         memtoreg;
        alu_func_e    alu_func;
        sft_func_e    sft_func;
        logic         intovf_en;
        logic         imm_sign;
        logic         mul_en;
        logic         mul_sign;
        logic         div_en;
        logic         div_sign;
        hilo_sel_e    hi_sel;
        hilo_sel_e    lo_sel;
        logic         hi_wen;
        logic         lo_wen;
        logic         pcsrc;                          // Branch taken
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
    import ctrl_pkg::*;
(
    input  instr_fields_t fields,
    output ctrl_word_t    ctrl
);

    function automatic ctrl_word_t alu_op(alu_func_e func, logic rtype, logic ovf, logic sext);
        ctrl_word_t c;
        c = '0;
        c.alu_srcb_sel_rt = rtype;
        c.regwrite = 1'b1;
        c.regdst = rtype ? REGDST_RD : REGDST_RT;
        c.alu_func = func;
        c.intovf_en = ovf;
        c.imm_sign = sext;
        return c;
    endfunction

    function automatic ctrl_word_t shift_op(sft_func_e func, logic var_amt);
        ctrl_word_t c;
        c = '0;
        c.sft_srcb_sel_rs = var_amt;                  // Amount from rs
        c.out_sel = OUT_SHIFT;
        c.regwrite = 1'b1;
        c.regdst = REGDST_RD;
        c.sft_func = func;
        return c;
    endfunction

    function automatic ctrl_word_t mem_op(mem_size_e size, logic wr, logic sext);
        ctrl_word_t c;
        c = '0;
        c.memreq = 1'b1;
        c.memwr = wr;
        c.memtoreg = ~wr;
        c.regwrite = ~wr;
        c.size = size;
        c.rdata_sign = sext;
        c.imm_sign = 1'b1;                            // Signed address offset
        return c;
    endfunction

    function automatic ctrl_word_t muldiv_op(logic div, logic sign);
        ctrl_word_t c;
        c = '0;
        c.alu_srcb_sel_rt = 1'b1;
        c.mul_en = ~div;
        c.mul_sign = sign & ~div;
        c.div_en = div;
        c.div_sign = sign & div;
        c.hi_sel = div ? HILO_DIV : HILO_MUL;
        c.lo_sel = div ? HILO_DIV : HILO_MUL;
        c.hi_wen = 1'b1;
        c.lo_wen = 1'b1;
        return c;
    endfunction

    function automatic ctrl_word_t branch_op(branch_cond_e cond, logic link);
        ctrl_word_t c;
        c = '0;
        c.isbranch = 1'b1;
        c.branch = cond;
        c.link = link;
        c.regwrite = link;
        c.regdst = link ? REGDST_RA : REGDST_RT;
        return c;
    endfunction

    function automatic ctrl_word_t jump_op(jump_kind_e kind, logic link, regdst_e dst);
        ctrl_word_t c;
        c = '0;
        c.isjump = 1'b1;
        c.jump = kind;
        c.link = link;
        c.regwrite = link;
        c.regdst = dst;
        return c;
    endfunction

    always_comb
    begin
        ctrl = '0;
        case (fields.op)
            6'b000000:                                // SPECIAL
            begin
                case (fields.funct)
                    6'b100000: ctrl = alu_op(ALU_ADD, 1'b1, 1'b1, 1'b0);   // ADD
                    6'b100001: ctrl = alu_op(ALU_ADD, 1'b1, 1'b0, 1'b0);   // ADDU
                    6'b100010: ctrl = alu_op(ALU_SUB, 1'b1, 1'b1, 1'b0);   // SUB
                    6'b100011: ctrl = alu_op(ALU_SUB, 1'b1, 1'b0, 1'b0);   // SUBU
                    6'b101010: ctrl = alu_op(ALU_SLT, 1'b1, 1'b0, 1'b0);   // SLT
                    6'b101011: ctrl = alu_op(ALU_SLTU, 1'b1, 1'b0, 1'b0);  // SLTU
                    6'b100100: ctrl = alu_op(ALU_AND, 1'b1, 1'b0, 1'b0);   // AND
                    6'b100101: ctrl = alu_op(ALU_OR, 1'b1, 1'b0, 1'b0);    // OR
                    6'b100110: ctrl = alu_op(ALU_XOR, 1'b1, 1'b0, 1'b0);   // XOR
                    6'b100111: ctrl = alu_op(ALU_NOR, 1'b1, 1'b0, 1'b0);   // NOR
                    6'b000000: ctrl = shift_op(SFT_SLL, 1'b0);             // SLL
                    6'b000010: ctrl = shift_op(SFT_SRL, 1'b0);             // SRL
                    6'b000011: ctrl = shift_op(SFT_SRA, 1'b0);             // SRA
                    6'b000100: ctrl = shift_op(SFT_SLL, 1'b1);             // SLLV
                    6'b000110: ctrl = shift_op(SFT_SRL, 1'b1);             // SRLV
                    6'b000111: ctrl = shift_op(SFT_SRA, 1'b1);             // SRAV
                    6'b011000: ctrl = muldiv_op(1'b0, 1'b1);               // MULT
                    6'b011001: ctrl = muldiv_op(1'b0, 1'b0);               // MULTU
                    6'b011010: ctrl = muldiv_op(1'b1, 1'b1);               // DIV
                    6'b011011: ctrl = muldiv_op(1'b1, 1'b0);               // DIVU
                    6'b001000: ctrl = jump_op(JMP_JR, 1'b0, REGDST_RT);    // JR
                    6'b001001: ctrl = jump_op(JMP_JALR, 1'b1, REGDST_RD);  // JALR
                    6'b010000:                        // MFHI
                    begin
                        ctrl.out_sel = OUT_HI;
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst = REGDST_RD;
                    end
                    6'b010010:                        // MFLO
                    begin
                        ctrl.out_sel = OUT_LO;
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst = REGDST_RD;
                    end
                    6'b010001:                        // MTHI
                    begin
                        ctrl.hi_sel = HILO_MOVE;
                        ctrl.hi_wen = 1'b1;
                    end
                    6'b010011:                        // MTLO
                    begin
                        ctrl.lo_sel = HILO_MOVE;
                        ctrl.lo_wen = 1'b1;
                    end
                    default: ctrl.reserved_instr = 1'b1;
                endcase
            end
            6'b000001:                                // REGIMM
            begin
                case (fields.regimm)
                    5'b00000: ctrl = branch_op(BR_LTZ, 1'b0);
                    5'b00001: ctrl = branch_op(BR_GEZ, 1'b0);
                    5'b10000: ctrl = branch_op(BR_LTZAL, 1'b1);
                    5'b10001: ctrl = branch_op(BR_GEZAL, 1'b1);
                    default:
                    begin
                        ctrl.reserved_instr = 1'b1;
                        ctrl.regwrite = 1'b1;         // Writes r31 as a link would
                        ctrl.regdst = REGDST_RA;
                    end
                endcase
            end
            6'b000100: ctrl = branch_op(BR_EQ, 1'b0);               // BEQ
            6'b000101: ctrl = branch_op(BR_NE, 1'b0);               // BNE
            6'b000110: ctrl = branch_op(BR_LEZ, 1'b0);              // BLEZ
            6'b000111: ctrl = branch_op(BR_GTZ, 1'b0);              // BGTZ
            6'b000010: ctrl = jump_op(JMP_J, 1'b0, REGDST_RT);      // J
            6'b000011: ctrl = jump_op(JMP_JAL, 1'b1, REGDST_RA);    // JAL
            6'b001000: ctrl = alu_op(ALU_ADD, 1'b0, 1'b1, 1'b1);    // ADDI
            6'b001001: ctrl = alu_op(ALU_ADD, 1'b0, 1'b0, 1'b1);    // ADDIU
            6'b001010: ctrl = alu_op(ALU_SLT, 1'b0, 1'b0, 1'b1);    // SLTI
            6'b001011: ctrl = alu_op(ALU_SLTU, 1'b0, 1'b0, 1'b1);   // SLTIU
            6'b001100: ctrl = alu_op(ALU_AND, 1'b0, 1'b0, 1'b0);    // ANDI
            6'b001101: ctrl = alu_op(ALU_OR, 1'b0, 1'b0, 1'b0);     // ORI
            6'b001110: ctrl = alu_op(ALU_XOR, 1'b0, 1'b0, 1'b0);    // XORI
            6'b001111:                                // LUI
            begin
                ctrl = shift_op(SFT_LUI, 1'b0);
                ctrl.regdst = REGDST_RT;
                ctrl.sft_srca_sel_imm = 1'b1;
            end
            6'b100000: ctrl = mem_op(SIZE_BYTE, 1'b0, 1'b1);        // LB
            6'b100001: ctrl = mem_op(SIZE_HALF, 1'b0, 1'b1);        // LH
            6'b100011: ctrl = mem_op(SIZE_WORD, 1'b0, 1'b1);        // LW
            6'b100100: ctrl = mem_op(SIZE_BYTE, 1'b0, 1'b0);        // LBU
            6'b100101: ctrl = mem_op(SIZE_HALF, 1'b0, 1'b0);        // LHU
            6'b101000: ctrl = mem_op(SIZE_BYTE, 1'b1, 1'b0);        // SB
            6'b101001: ctrl = mem_op(SIZE_HALF, 1'b1, 1'b0);        // SH
            6'b101011: ctrl = mem_op(SIZE_WORD, 1'b1, 1'b0);        // SW
            default: ctrl.reserved_instr = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: source/pipe_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module pipe_controller
    import ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  instr_fields_t  dinstr,
    input  compare_flags_t dcompare,
    input  stage_mask_t    flush,
    input  stage_mask_t    stall,
    output ctrl_word_t     dstage,
    output ctrl_word_t     estage,
    output ctrl_word_t     mstage,
    output ctrl_word_t     wstage
);

    ctrl_word_t decoded;                              // pcsrc still clear
    ctrl_word_t pipe [0:`CTRL_STAGES];                // Index 0 is decode

    instr_decoder i_instr_decoder (
        .fields (dinstr),
        .ctrl   (decoded)
    );

    branch_resolver i_branch_resolver (
        .ctrl_in  (decoded),
        .compare  (dcompare),
        .ctrl_out (pipe[0])
    );

    generate
        for (genvar i = 0; i < `CTRL_STAGES; i++)
        begin : g_stage
            stage_register i_stage_register (
                .clk   (clk),
                .reset (reset),
                .flush (flush[i]),
                .stall (stall[i]),
                .d     (pipe[i]),
                .q     (pipe[i+1])
            );
        end
    endgenerate

    assign dstage = pipe[0];
    assign estage = pipe[1];
    assign mstage = pipe[2];
    assign wstage = pipe[3];

endmodule

`default_nettype wire

// File: source/stage_register.sv
`timescale 1ns/100ps
`default_nettype none

module stage_register
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       stall,
    input  ctrl_word_t d,
    output ctrl_word_t q
);

    always_ff @(posedge clk)
    begin
        if (reset || flush)
            q <= '0;                                  // Bubble with all controls inactive
        else if (!stall)
            q <= d;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/ctrl_pkg.sv
source/instr_decoder.sv
source/branch_resolver.sv
source/stage_register.sv
source/pipe_controller.sv
dv/tb_pipe_controller.sv
